// ==== cpu_pkg.sv ====
/*
 * Shared definitions for the multicycle 32-bit core
 * Widths, opcodes, FSM states, flag positions, instruction and bus types
 */
package cpu_pkg;

    // ----------------------------------------------------------
    // Widths and constants
    // ----------------------------------------------------------
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;                     // 32 registers
    localparam int OPC_W  = 6;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_8000; // First fetch
    localparam logic [XLEN-1:0] PC_STEP  = 32'd4;

    // Flag bit positions, bits 7..4 stay zero
    localparam int FLAG_C = 0;
    localparam int FLAG_Z = 1;
    localparam int FLAG_N = 2;
    localparam int FLAG_V = 3;

    // ----------------------------------------------------------
    // Opcodes
    // ----------------------------------------------------------
    typedef enum logic [OPC_W-1:0] {
        OP_ADD   = 6'h00, OP_SUB   = 6'h01, OP_AND  = 6'h02,
        OP_OR    = 6'h03, OP_XOR   = 6'h04, OP_NOT  = 6'h05,
        OP_SHL   = 6'h06, OP_SHR   = 6'h07, OP_CMP  = 6'h0B,
        OP_SAR   = 6'h0C, OP_ADDI  = 6'h0D, OP_SUBI = 6'h0E,
        OP_CMPI  = 6'h0F,
        OP_LOAD  = 6'h10, OP_STORE = 6'h11, OP_LOADI = 6'h12,
        OP_JMP   = 6'h20, OP_JZ    = 6'h21, OP_JNZ  = 6'h22,
        OP_JC    = 6'h23, OP_JNC   = 6'h24, OP_JLT  = 6'h25,
        OP_JGE   = 6'h26, OP_JLE   = 6'h27,
        OP_SETEQ = 6'h30, OP_SETNE = 6'h31, OP_SETLT = 6'h32,
        OP_SETGE = 6'h33, OP_SETLE = 6'h34, OP_SETGT = 6'h35,
        OP_HALT  = 6'h3E
    } opcode_e;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,   // Loads and stores only
        WRITEBACK = 3'd4
    } cpu_state_e;

    // ----------------------------------------------------------
    // Instruction word, register form and immediate form
    // ----------------------------------------------------------
    typedef struct packed {
        logic [OPC_W-1:0]  opcode;
        logic [1:0]        spare_hi;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [8:0]        spare_lo;
    } instr_r_t;

    typedef struct packed {
        logic [OPC_W-1:0]  opcode;
        logic [1:0]        spare_hi;
        logic [REG_AW-1:0] rd;
        logic [18:0]       imm19;    // Low 12 bits are the short immediate
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } cpu_instr_u;

    // Decoded control word
    typedef struct packed {
        opcode_e           op;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   imm;       // Already extended
        logic              use_imm;
        logic              reg_write;
        logic              flag_write;
        logic              is_load;
        logic              is_store;
        logic              is_branch;
        logic              is_set;
        logic              is_halt;
    } cpu_decoded_t;

    // Memory request toward the bus
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic            read;
        logic            write;
    } mem_req_t;

endpackage

// ==== cpu_regfile.sv ====
/*
 * Register file, 32 x 32 bits
 * Two combinational read ports, one clocked write port
 */
module cpu_regfile (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    input  logic [4:0]  waddr,
    input  logic        we,
    input  logic [31:0] wdata,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b
);

    logic [cpu_pkg::XLEN-1:0] regs [2**cpu_pkg::REG_AW];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**cpu_pkg::REG_AW; i++)
                regs[i] <= '0;
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Async reads
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];

endmodule

// ==== cpu_decoder.sv ====
/*
 * Instruction decoder
 * Splits the instruction word into control fields and an extended immediate
 */
module cpu_decoder (
    input  cpu_pkg::cpu_instr_u   instr,
    output cpu_pkg::cpu_decoded_t dec
);

    cpu_pkg::opcode_e opc;

    assign opc = cpu_pkg::opcode_e'(instr.r.opcode);

    always_comb begin
        dec     = '0;   // Unknown opcodes fall through as no-op
        dec.op  = opc;
        dec.rd  = instr.r.rd;
        dec.rs1 = instr.r.rs1;
        dec.rs2 = instr.r.rs2;
        // Short signed immediate, used by ADDI/SUBI/CMPI and branches
        dec.imm = {{20{instr.i.imm19[11]}}, instr.i.imm19[11:0]};

        case (opc)
            cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_AND,
            cpu_pkg::OP_OR,  cpu_pkg::OP_XOR, cpu_pkg::OP_NOT,
            cpu_pkg::OP_SHL, cpu_pkg::OP_SHR, cpu_pkg::OP_SAR: begin
                dec.reg_write  = 1'b1;
                dec.flag_write = 1'b1;
            end
            cpu_pkg::OP_CMP: dec.flag_write = 1'b1;       // Flags only
            cpu_pkg::OP_ADDI, cpu_pkg::OP_SUBI: begin
                dec.use_imm    = 1'b1;
                dec.reg_write  = 1'b1;
                dec.flag_write = 1'b1;
            end
            cpu_pkg::OP_CMPI: begin
                dec.use_imm    = 1'b1;
                dec.flag_write = 1'b1;
            end
            cpu_pkg::OP_LOAD: begin
                dec.is_load   = 1'b1;
                dec.reg_write = 1'b1;
            end
            cpu_pkg::OP_STORE: begin
                dec.is_store = 1'b1;
                dec.rs2      = instr.r.rd;  // Store data comes out of port b
            end
            cpu_pkg::OP_LOADI: begin
                dec.reg_write = 1'b1;
                dec.imm       = {13'd0, instr.i.imm19};   // Zero extended
            end
            cpu_pkg::OP_JMP, cpu_pkg::OP_JZ,  cpu_pkg::OP_JNZ, cpu_pkg::OP_JC,
            cpu_pkg::OP_JNC, cpu_pkg::OP_JLT, cpu_pkg::OP_JGE, cpu_pkg::OP_JLE:
                dec.is_branch = 1'b1;
            cpu_pkg::OP_SETEQ, cpu_pkg::OP_SETNE, cpu_pkg::OP_SETLT,
            cpu_pkg::OP_SETGE, cpu_pkg::OP_SETLE, cpu_pkg::OP_SETGT: begin
                dec.is_set    = 1'b1;
                dec.reg_write = 1'b1;
            end
            cpu_pkg::OP_HALT: dec.is_halt = 1'b1;
            default: ;
        endcase
    end

endmodule

// ==== cpu_execute.sv ====
/*
 * Execute unit
 * ALU, flags register, result register, SET value and branch condition
 */
module cpu_execute (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  exec_en,
    input  cpu_pkg::cpu_decoded_t dec,
    input  logic [31:0]           rdata_a,
    input  logic [31:0]           rdata_b,
    output logic [31:0]           result,
    output logic [7:0]            flags,
    output logic                  branch_taken
);

    localparam int W = cpu_pkg::XLEN;

    logic [W-1:0] op_b, alu_res;
    logic [W:0]   sum, diff;        // Extra bit holds carry or borrow
    logic         alu_c, alu_v;
    logic [7:0]   flags_d;
    logic         set_bit, cond;

    assign op_b = dec.use_imm ? dec.imm : rdata_b;
    assign sum  = {1'b0, rdata_a} + {1'b0, op_b};
    assign diff = {1'b0, rdata_a} - {1'b0, op_b};

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------
    always_comb begin
        alu_res = sum[W-1:0];
        alu_c   = 1'b0;     // Logic and shifts clear C and V
        alu_v   = 1'b0;
        case (dec.op)
            cpu_pkg::OP_ADD, cpu_pkg::OP_ADDI: begin
                alu_c = sum[W];
                alu_v = (rdata_a[W-1] == op_b[W-1]) && (sum[W-1] != rdata_a[W-1]);
            end
            cpu_pkg::OP_SUB, cpu_pkg::OP_SUBI, cpu_pkg::OP_CMP, cpu_pkg::OP_CMPI: begin
                alu_res = diff[W-1:0];
                alu_c   = diff[W];  // Unsigned a < b
                alu_v   = (rdata_a[W-1] != op_b[W-1]) && (diff[W-1] != rdata_a[W-1]);
            end
            cpu_pkg::OP_AND: alu_res = rdata_a & op_b;
            cpu_pkg::OP_OR:  alu_res = rdata_a | op_b;
            cpu_pkg::OP_XOR: alu_res = rdata_a ^ op_b;
            cpu_pkg::OP_NOT: alu_res = ~rdata_a;
            cpu_pkg::OP_SHL: alu_res = rdata_a << op_b[4:0];
            cpu_pkg::OP_SHR: alu_res = rdata_a >> op_b[4:0];
            cpu_pkg::OP_SAR: alu_res = $signed(rdata_a) >>> op_b[4:0];
            default: ;
        endcase
    end

    always_comb begin
        flags_d                 = '0;
        flags_d[cpu_pkg::FLAG_C] = alu_c;
        flags_d[cpu_pkg::FLAG_Z] = (alu_res == '0);
        flags_d[cpu_pkg::FLAG_N] = alu_res[W-1];
        flags_d[cpu_pkg::FLAG_V] = alu_v;
    end

    // SET value and branch condition, both from stored flags
    always_comb begin
        set_bit = 1'b0;
        cond    = 1'b0;
        case (dec.op)
            cpu_pkg::OP_SETEQ: set_bit = flags[cpu_pkg::FLAG_Z];
            cpu_pkg::OP_SETNE: set_bit = !flags[cpu_pkg::FLAG_Z];
            cpu_pkg::OP_SETLT: set_bit = flags[cpu_pkg::FLAG_N];
            cpu_pkg::OP_SETGE: set_bit = !flags[cpu_pkg::FLAG_N];
            cpu_pkg::OP_SETLE: set_bit = flags[cpu_pkg::FLAG_N] || flags[cpu_pkg::FLAG_Z];
            cpu_pkg::OP_SETGT: set_bit = !flags[cpu_pkg::FLAG_N] && !flags[cpu_pkg::FLAG_Z];
            cpu_pkg::OP_JMP:   cond    = 1'b1;
            cpu_pkg::OP_JZ:    cond    = flags[cpu_pkg::FLAG_Z];
            cpu_pkg::OP_JNZ:   cond    = !flags[cpu_pkg::FLAG_Z];
            cpu_pkg::OP_JC:    cond    = flags[cpu_pkg::FLAG_C];
            cpu_pkg::OP_JNC:   cond    = !flags[cpu_pkg::FLAG_C];
            cpu_pkg::OP_JLT:   cond    = flags[cpu_pkg::FLAG_N];
            cpu_pkg::OP_JGE:   cond    = !flags[cpu_pkg::FLAG_N];
            cpu_pkg::OP_JLE:   cond    = flags[cpu_pkg::FLAG_N] || flags[cpu_pkg::FLAG_Z];
            default: ;
        endcase
    end

    assign branch_taken = dec.is_branch && cond;

    // ----------------------------------------------------------
    // Registers
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            flags <= '0;
        else if (exec_en && dec.flag_write)
            flags <= flags_d;
    end

    always_ff @(posedge clk) begin
        if (exec_en) begin
            if (dec.is_set)
                result <= {{(W-1){1'b0}}, set_bit};
            else if (dec.op == cpu_pkg::OP_LOADI)
                result <= dec.imm;
            else
                result <= alu_res;
        end
    end

endmodule

// ==== cpu_sequencer.sv ====
/*
 * Core sequencer
 * FSM, PC, instruction and load data registers, halt flag,
 * memory request and writeback select
 */
module cpu_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [31:0]          mem_rdata,
    input  logic                 mem_ready,
    input  cpu_pkg::cpu_decoded_t dec,
    input  logic [31:0]          result,
    input  logic                 branch_taken,
    input  logic [31:0]          rdata_a,
    input  logic [31:0]          rdata_b,
    output cpu_pkg::cpu_instr_u  instr,
    output cpu_pkg::mem_req_t    mem_req,
    output logic                 exec_en,
    output logic                 reg_we,
    output logic [31:0]          reg_wdata,
    output logic                 halted
);

    cpu_pkg::cpu_state_e          state_q, state_d;
    logic [cpu_pkg::XLEN-1:0]     pc_q;
    logic [cpu_pkg::XLEN-1:0]     ld_data_q;
    logic                         advance;

    assign advance = mem_ready && !halted;  // Stall on mem_ready, freeze once halted
    assign exec_en = advance && (state_q == cpu_pkg::EXECUTE);

    // ----------------------------------------------------------
    // Next state
    // ----------------------------------------------------------
    always_comb begin
        case (state_q)
            cpu_pkg::FETCH:     state_d = cpu_pkg::DECODE;
            cpu_pkg::DECODE:    state_d = cpu_pkg::EXECUTE;
            cpu_pkg::EXECUTE:   state_d = (dec.is_load || dec.is_store) ?
                                          cpu_pkg::MEMORY : cpu_pkg::WRITEBACK;
            cpu_pkg::MEMORY:    state_d = cpu_pkg::WRITEBACK;
            default:            state_d = cpu_pkg::FETCH;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= cpu_pkg::FETCH;
            pc_q    <= cpu_pkg::RESET_PC;
            instr   <= '0;
            halted  <= 1'b0;
        end else if (advance) begin
            state_q <= state_d;
            case (state_q)
                cpu_pkg::FETCH: begin
                    instr <= mem_rdata;
                    pc_q  <= pc_q + cpu_pkg::PC_STEP;
                end
                cpu_pkg::EXECUTE: begin
                    // PC already points past the branch
                    if (branch_taken)
                        pc_q <= pc_q + {dec.imm[cpu_pkg::XLEN-3:0], 2'b00};
                    if (dec.is_halt)
                        halted <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    // Load data capture
    always_ff @(posedge clk) begin
        if (advance && state_q == cpu_pkg::MEMORY && dec.is_load)
            ld_data_q <= mem_rdata;
    end

    // ----------------------------------------------------------
    // Memory request
    // ----------------------------------------------------------
    always_comb begin
        mem_req.addr  = pc_q;
        mem_req.wdata = rdata_b;        // Register rd on a store
        mem_req.read  = 1'b0;
        mem_req.write = 1'b0;
        if (!halted) begin
            if (state_q == cpu_pkg::FETCH) begin
                mem_req.read = 1'b1;
            end else if (state_q == cpu_pkg::MEMORY) begin
                mem_req.addr  = rdata_a;                // Register rs1
                mem_req.read  = dec.is_load;
                mem_req.write = dec.is_store;
            end
        end
    end

    // Writeback select
    assign reg_we    = advance && (state_q == cpu_pkg::WRITEBACK) && dec.reg_write;
    assign reg_wdata = dec.is_load ? ld_data_q : result;

endmodule

// ==== cpu_core.sv ====
/*
 * Multicycle 32-bit core top level
 * Sequencer, decoder, register file and execute unit
 */
module cpu_core (
    input  logic              clk,
    input  logic              rst_n,
    output cpu_pkg::mem_req_t mem_req,
    input  logic [31:0]       mem_rdata,
    input  logic              mem_ready,
    output logic              halted,
    output logic [7:0]        cpu_flags
);

    cpu_pkg::cpu_instr_u   instr;
    cpu_pkg::cpu_decoded_t dec;
    logic [31:0]           rdata_a, rdata_b;
    logic [31:0]           result;
    logic [31:0]           reg_wdata;
    logic                  reg_we;
    logic                  exec_en;
    logic                  branch_taken;

    // ----------------------------------------------------------
    // Input side
    // ----------------------------------------------------------
    cpu_sequencer u_sequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .dec          (dec),
        .result       (result),
        .branch_taken (branch_taken),
        .rdata_a      (rdata_a),
        .rdata_b      (rdata_b),
        .instr        (instr),
        .mem_req      (mem_req),
        .exec_en      (exec_en),
        .reg_we       (reg_we),
        .reg_wdata    (reg_wdata),
        .halted       (halted)
    );

    cpu_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    // ----------------------------------------------------------
    // Processing part
    // ----------------------------------------------------------
    cpu_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .raddr_a (dec.rs1),
        .raddr_b (dec.rs2),     // Holds rd on a store
        .waddr   (dec.rd),
        .we      (reg_we),
        .wdata   (reg_wdata),
        .rdata_a (rdata_a),
        .rdata_b (rdata_b)
    );

    cpu_execute u_execute (
        .clk          (clk),
        .rst_n        (rst_n),
        .exec_en      (exec_en),
        .dec          (dec),
        .rdata_a      (rdata_a),
        .rdata_b      (rdata_b),
        .result       (result),
        .flags        (cpu_flags),
        .branch_taken (branch_taken)
    );

endmodule

// ==== cpu_assertions.sv ====
/*
 * Bound checks on the core's memory request and halt behavior
 */
module cpu_assertions (
    input logic              clk,
    input logic              rst_n,
    input cpu_pkg::mem_req_t mem_req,
    input logic              halted
);

    // Never read and write in the same cycle
    a_rw_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(mem_req.read && mem_req.write)
    ) else $error("read and write asserted together");

    // A frozen core starts no store
    a_no_write_when_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        $rose(mem_req.write) |-> !halted
    ) else $error("write rose while halted");

    // Halt is sticky until reset
    a_halt_sticky: assert property (
        @(posedge clk) disable iff (!rst_n)
        halted |=> halted
    ) else $error("halted fell without reset");

endmodule

bind cpu_core cpu_assertions u_assertions (
    .clk     (clk),
    .rst_n   (rst_n),
    .mem_req (mem_req),
    .halted  (halted)
);

// ==== tb_cpu_core.sv ====
/*
 * Testbench for the multicycle core
 * Trace-driven memory model with random mem_ready stalls
 */
module tb_cpu_core;

    localparam int HALT_TIMEOUT = 20000;    // Cycles allowed until HALT
    localparam int QUIET_CYCLES = 64;       // Watch window after HALT

    logic              clk = 1'b0;
    logic              rst_n;
    cpu_pkg::mem_req_t mem_req;
    logic [31:0]       mem_rdata;
    logic              mem_ready;
    logic              halted;
    logic [7:0]        cpu_flags;

    logic [31:0] mem [logic [31:0]];       // Sparse memory for program and data
    logic [31:0] exp_addr_q[$];
    logic [31:0] exp_data_q[$];
    logic [7:0]  exp_flags;
    int          err_store;
    int          err_flags;
    int          err_req;
    int          err_other;

    cpu_core dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_req   (mem_req),
        .mem_rdata (mem_rdata),
        .mem_ready (mem_ready),
        .halted    (halted),
        .cpu_flags (cpu_flags)
    );

    always #4 clk = ~clk;

    // ------------------------------------------------------------
    // Trace reader for the P D S F line tags
    // ------------------------------------------------------------
    task automatic load_trace();
        int          fd;
        int          n;
        byte         kind;
        logic [31:0] a;
        logic [31:0] d;
        string       line;
        fd = $fopen("cpu_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file cpu_trace.txt");
            err_other++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            kind = 8'h00;
            n = $fgets(line, fd);
            if (n > 0) begin
                n = $sscanf(line, "%c %h %h", kind, a, d);
                case (kind)
                    "P", "D": mem[a] = d;
                    "S": begin
                        exp_addr_q.push_back(a);
                        exp_data_q.push_back(d);
                    end
                    "F": exp_flags = a[7:0];
                    default: ;                  // Comments and blank lines
                endcase
            end
        end
        $fclose(fd);
    endtask

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_store(input cpu_pkg::mem_req_t req);
        logic [31:0] ea;
        logic [31:0] ed;
        if (exp_addr_q.size() == 0) begin
            $display("Unexpected store to %h with data %h at time %0t",
                     req.addr, req.wdata, $time);
            err_store++;
        end else begin
            ea = exp_addr_q.pop_front();
            ed = exp_data_q.pop_front();
            if (req.addr !== ea || req.wdata !== ed) begin
                $display("** Error at %0t: store %h <- %h, expected %h <- %h",
                         $time, req.addr, req.wdata, ea, ed);
                err_store++;
            end
        end
    endtask

    task automatic check_flags(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: flags %h, expected %h", $time, got, exp);
            err_flags++;
        end
    endtask

    task automatic compare_reset_request(input cpu_pkg::mem_req_t req, input logic hlt);
        if (req.read !== 1'b1 || req.write !== 1'b0 || hlt !== 1'b0 ||
            req.addr !== cpu_pkg::RESET_PC) begin
            $display("** Error at %0t: first request addr %h rd %b wr %b halted %b",
                     $time, req.addr, req.read, req.write, hlt);
            err_req++;
        end
    endtask

    // Memory model driving everything on the falling edge
    initial begin
        mem_ready = 1'b0;
        mem_rdata = 32'h0;
        void'($urandom(32'h540e55cc));
        forever begin
            @(negedge clk);
            mem_ready = ($urandom % 4) != 0;    // Stall about one cycle in four
            // Data only comes back for a read request
            if (mem_req.read && mem.exists(mem_req.addr))
                mem_rdata = mem[mem_req.addr];
            else
                mem_rdata = 32'h0;
            if (rst_n && mem_req.write && mem_ready) begin
                check_store(mem_req);
                mem[mem_req.addr] = mem_req.wdata;
            end
        end
    end

    initial begin
        int cyc;
        rst_n     = 1'b0;
        exp_flags = 8'h00;
        err_store = 0;
        err_flags = 0;
        err_req   = 0;
        err_other = 0;
        load_trace();

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        compare_reset_request(mem_req, halted);

        cyc = 0;
        while (!halted && cyc < HALT_TIMEOUT) begin
            @(negedge clk);
            cyc++;
        end
        if (!halted) begin
            $display("Timeout: the core did not halt within %0d cycles", HALT_TIMEOUT);
            err_other++;
        end else begin
            // Any store in this window is flagged by the memory model
            cyc = 0;
            while (cyc < QUIET_CYCLES) begin
                @(negedge clk);
                cyc++;
            end
            if (exp_addr_q.size() != 0) begin
                $display("%0d expected stores never appeared", exp_addr_q.size());
                err_store++;
            end
            check_flags(cpu_flags, exp_flags);
        end

        $display("Errors: store %0d, flags %0d, request %0d, other %0d",
                 err_store, err_flags, err_req, err_other);
        if (err_store + err_flags + err_req + err_other == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== cpu_trace.txt ====
# P addr word = program, D addr word = data preload
# S addr data = expected store in order, F flags = final flags
P 00008000 48081000
P 00008004 48100007
P 00008008 48180005
P 0000800c 00208600
P 00008010 44204000
P 00008014 0420c400
P 00008018 44204000
P 0000801c 08208600
P 00008020 44204000
P 00008024 0c208600
P 00008028 44204000
P 0000802c 10208600
P 00008030 44204000
P 00008034 14208000
P 00008038 44204000
P 0000803c 14300000
P 00008040 18208600
P 00008044 44204000
P 00008048 1c218600
P 0000804c 44204000
P 00008050 30218600
P 00008054 44204000
P 00008058 34208ffd
P 0000805c 44204000
P 00008060 38208ffd
P 00008064 44204000
P 00008068 48382000
P 0000806c 4041c000
P 00008070 00420400
P 00008074 4441c000
P 00008078 2c008600
P 0000807c 80000001
P 00008080 44104000
P 00008084 84000001
P 00008088 44104000
P 0000808c 88000001
P 00008090 44184000
P 00008094 8c000001
P 00008098 44184000
P 0000809c 90000001
P 000080a0 44304000
P 000080a4 94000001
P 000080a8 44304000
P 000080ac 98000001
P 000080b0 44384000
P 000080b4 9c000001
P 000080b8 44384000
P 000080bc 3c00c007
P 000080c0 8c000001
P 000080c4 44104000
P 000080c8 90000001
P 000080cc 44184000
P 000080d0 c0500000
P 000080d4 44504000
P 000080d8 c4580000
P 000080dc 44584000
P 000080e0 c8600000
P 000080e4 44604000
P 000080e8 cc680000
P 000080ec 44684000
P 000080f0 d0700000
P 000080f4 44704000
P 000080f8 d4780000
P 000080fc 44784000
P 00008100 f8000000
D 00002000 00000064
S 00001000 0000000c
S 00001000 fffffffe
S 00001000 00000005
S 00001000 00000007
S 00001000 00000002
S 00001000 fffffff8
S 00001000 000000e0
S 00001000 07ffffff
S 00001000 ffffffff
S 00001000 00000004
S 00001000 0000000a
S 00002000 0000006b
S 00001000 00000007
S 00001000 00000005
S 00001000 ffffffff
S 00001000 00002000
S 00001000 00000005
S 00001000 00000000
S 00001000 00000001
S 00001000 00000001
S 00001000 00000000
S 00001000 00000001
S 00001000 00000000
F 05

// ==== filelist.f ====
cpu_pkg.sv
cpu_regfile.sv
cpu_decoder.sv
cpu_execute.sv
cpu_sequencer.sv
cpu_core.sv
cpu_assertions.sv
tb_cpu_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f filelist.f --top-module tb_cpu_core -o sim_cpu
status=0
./obj_dir/sim_cpu > sim.log 2>&1 || status=$?
cat sim.log
if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "=== PASS ===" sim.log; then
    exit 1
fi
exit 0
